/* eth_hub_config.svh */
`ifndef ETH_HUB_CONFIG_SVH
`define ETH_HUB_CONFIG_SVH

// number of hub ports
`define NUM_PORTS 3

// words per port FIFO
// a frame longer than this is cut to this length
`define FIFO_DEPTH 64

// idle cycles on every tx lane between two forwarded frames
// must be 3 or more
`define IFG_BYTES 12

`endif

/* eth_hub_pkg.sv */
package eth_hub_pkg;

  // one byte lane, used for rx and tx alike
  typedef struct packed {
    logic       v;
    logic [7:0] d;
  } phy_byte_t;

  // buffered byte
  typedef struct packed {
    logic       last; // end of frame
    logic [7:0] d;
  } fifo_word_t;

  // forwarder states
  typedef enum logic [1:0] {
    fwd_idle,  // waiting for a complete frame
    fwd_grant, // source latched, first read
    fwd_send,  // one byte per cycle to the other ports
    fwd_gap    // inter-frame gap
  } fwd_state_e;

endpackage : eth_hub_pkg

/* hub_port_rx.sv */
`timescale 1ns/10ps

module hub_port_rx (
  input  logic                    clk,
  input  logic                    rst,
  input  eth_hub_pkg::phy_byte_t  rx,
  input  logic                    full,
  output logic                    wr_en,
  output eth_hub_pkg::fifo_word_t wr_data,
  output logic [15:0]             trunc_count
);

  eth_hub_pkg::phy_byte_t held; // byte seen in the previous cycle
  logic                   drop; // discarding the tail of a cut frame
  logic                   pending;
  logic                   cut;

  // The byte is held one cycle so that its last flag is known when it
  // is written. The frame ends when valid falls behind it.
  assign pending = held.v && !drop;
  assign wr_en   = pending && !full;
  assign wr_data = '{last: !rx.v, d: held.d};

  // A write that takes the final FIFO slot is tagged last by the FIFO, so
  // a cut frame in the buffer is always closed. Seeing full with a byte
  // still pending means that frame lost its tail, or that a new frame
  // started with no room at all.
  assign cut = pending && full;

  always_ff @(posedge clk) begin
    held.d <= rx.d;
    if (rst) begin
      held.v      <= 1'b0;
      drop        <= 1'b0;
      trunc_count <= '0;
    end else begin
      held.v <= rx.v;

      if (cut && rx.v) begin
        drop <= 1'b1; // frame still running
      end else if (!rx.v) begin
        drop <= 1'b0; // frame over, next one starts clean
      end

      if (cut) begin
        trunc_count <= trunc_count + 16'd1; // once per cut frame
      end
    end
  end

  // the FIFO never sees a write it cannot take
  a_no_write_full : assert property (
    @(posedge clk) disable iff (rst)
    !(wr_en && full)
  );

endmodule : hub_port_rx

/* frame_fifo.sv */
`timescale 1ns/10ps
`include "eth_hub_config.svh"

module frame_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_en,
  input  eth_hub_pkg::fifo_word_t wr_data,
  input  logic                    rd_en,
  output eth_hub_pkg::fifo_word_t rd_data,
  output logic                    full,
  output logic                    empty,
  output logic                    frame_ready
);

  localparam int AW = $clog2(`FIFO_DEPTH);
  localparam int CW = $clog2(`FIFO_DEPTH + 1);

  eth_hub_pkg::fifo_word_t mem [`FIFO_DEPTH];
  eth_hub_pkg::fifo_word_t wr_word;
  logic [AW-1:0]           wr_ptr;
  logic [AW-1:0]           rd_ptr;
  logic [CW-1:0]           count;  // words held
  logic [CW-1:0]           frames; // complete frames held
  logic                    fill;
  logic                    frame_in;
  logic                    frame_out;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(`FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full        = (count == CW'(`FIFO_DEPTH));
  assign empty       = (count == '0);
  assign frame_ready = (frames != '0);

  // a write into the last free slot closes its frame, so a frame cut by
  // overflow still counts and can be forwarded
  assign fill    = wr_en && !rd_en && (count == CW'(`FIFO_DEPTH - 1));
  assign wr_word = '{last: wr_data.last || fill, d: wr_data.d};

  assign frame_in  = wr_en && wr_word.last;
  assign frame_out = rd_en && mem[rd_ptr].last;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
    if (rd_en) begin
      rd_data <= mem[rd_ptr]; // valid the cycle after rd_en
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      frames <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count  <= count + CW'(wr_en) - CW'(rd_en);
      frames <= frames + CW'(frame_in) - CW'(frame_out);
    end
  end

  // the forwarder reads only whole frames, so it never runs dry
  a_no_read_empty : assert property (
    @(posedge clk) disable iff (rst)
    rd_en |-> !empty
  );

endmodule : frame_fifo

/* rr_arbiter.sv */
`timescale 1ns/10ps
`include "eth_hub_config.svh"

module rr_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  logic                  accept,
  output logic [`NUM_PORTS-1:0] grant
);

  localparam int PW = $clog2(`NUM_PORTS);

  logic [PW-1:0] ptr;     // port with top priority
  logic [PW-1:0] gnt_idx;

  // first requester at or after ptr, wrapping around
  always_comb begin
    int   idx;
    logic found;
    grant   = '0;
    gnt_idx = ptr;
    found   = 1'b0;
    for (int k = 0; k < `NUM_PORTS; k++) begin
      idx = int'(ptr) + k;
      if (idx >= `NUM_PORTS) begin
        idx = idx - `NUM_PORTS;
      end
      if (!found && req[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        gnt_idx    = PW'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (accept) begin
      ptr <= (gnt_idx == PW'(`NUM_PORTS - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  a_grant_onehot : assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  );

endmodule : rr_arbiter

/* hub_forwarder.sv */
`timescale 1ns/10ps
`include "eth_hub_config.svh"

module hub_forwarder (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [`NUM_PORTS-1:0]                    grant,
  output logic                                     accept,
  output logic [`NUM_PORTS-1:0]                    rd_en,
  input  eth_hub_pkg::fifo_word_t [`NUM_PORTS-1:0] rd_data,
  output eth_hub_pkg::phy_byte_t  [`NUM_PORTS-1:0] tx
);

  localparam int GW = $clog2(`IFG_BYTES + 1);

  // Three cycles pass from grant to the first byte on tx, so the gap state
  // is that much shorter than IFG_BYTES. Granting right after the gap
  // then leaves exactly IFG_BYTES idle cycles on the lines.
  localparam int GAP_LOAD = `IFG_BYTES - 3;

  eth_hub_pkg::fwd_state_e state;
  logic [`NUM_PORTS-1:0]   src;  // one-hot source port
  eth_hub_pkg::fifo_word_t word; // word read from the source
  logic [GW-1:0]           gap_cnt;

  assign accept = (state == eth_hub_pkg::fwd_idle) && (grant != '0);

  always_comb begin
    word = '0;
    for (int i = 0; i < `NUM_PORTS; i++) begin
      if (src[i]) begin
        word = rd_data[i];
      end
    end
  end

  // first read in fwd_grant, then one per cycle until last comes back
  always_comb begin
    rd_en = '0;
    case (state)
      eth_hub_pkg::fwd_grant: begin
        rd_en = src;
      end
      eth_hub_pkg::fwd_send: begin
        if (!word.last) begin
          rd_en = src;
        end
      end
      default: begin
        rd_en = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= eth_hub_pkg::fwd_idle;
      src     <= '0;
      gap_cnt <= '0;
    end else begin
      case (state)
        eth_hub_pkg::fwd_idle: begin
          if (accept) begin
            src   <= grant;
            state <= eth_hub_pkg::fwd_grant;
          end
        end
        eth_hub_pkg::fwd_grant: begin
          state <= eth_hub_pkg::fwd_send;
        end
        eth_hub_pkg::fwd_send: begin
          if (word.last) begin
            gap_cnt <= GW'(GAP_LOAD);
            state   <= eth_hub_pkg::fwd_gap;
          end
        end
        eth_hub_pkg::fwd_gap: begin
          if (gap_cnt == '0) begin
            state <= eth_hub_pkg::fwd_idle;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        default: begin
          state <= eth_hub_pkg::fwd_idle;
        end
      endcase
    end
  end

  // broadcast, the source lane stays quiet
  always_ff @(posedge clk) begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      tx[i].d <= word.d;
      if (rst) begin
        tx[i].v <= 1'b0;
      end else begin
        tx[i].v <= (state == eth_hub_pkg::fwd_send) && !src[i];
      end
    end
  end

  a_one_reader : assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(rd_en)
  );

endmodule : hub_forwarder

/* eth_hub_top.sv */
`timescale 1ns/10ps
`include "eth_hub_config.svh"

module eth_hub_top (
  input  logic                                    clk,
  input  logic                                    rst,
  input  eth_hub_pkg::phy_byte_t [`NUM_PORTS-1:0] rx_in,
  output eth_hub_pkg::phy_byte_t [`NUM_PORTS-1:0] tx_out,
  output logic [`NUM_PORTS-1:0][15:0]             trunc_count
);

  logic [`NUM_PORTS-1:0]                    wr_en;
  eth_hub_pkg::fifo_word_t [`NUM_PORTS-1:0] wr_data;
  logic [`NUM_PORTS-1:0]                    full;
  logic [`NUM_PORTS-1:0]                    frame_ready;
  logic [`NUM_PORTS-1:0]                    rd_en;
  eth_hub_pkg::fifo_word_t [`NUM_PORTS-1:0] rd_data;
  logic [`NUM_PORTS-1:0]                    grant;
  logic                                     accept;

  // receive side and buffer for each port
  for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
    hub_port_rx i_rx (
      .clk         (clk),
      .rst         (rst),
      .rx          (rx_in[i]),
      .full        (full[i]),
      .wr_en       (wr_en[i]),
      .wr_data     (wr_data[i]),
      .trunc_count (trunc_count[i])
    );

    frame_fifo i_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en       (wr_en[i]),
      .wr_data     (wr_data[i]),
      .rd_en       (rd_en[i]),
      .rd_data     (rd_data[i]),
      .full        (full[i]),
      .empty       (),
      .frame_ready (frame_ready[i])
    );
  end

  rr_arbiter i_arb (
    .clk    (clk),
    .rst    (rst),
    .req    (frame_ready),
    .accept (accept),
    .grant  (grant)
  );

  hub_forwarder i_fwd (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .accept  (accept),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .tx      (tx_out)
  );

endmodule : eth_hub_top

/* tb_eth_hub.sv */
`timescale 1ns/10ps
`include "eth_hub_config.svh"

module tb_eth_hub;

  localparam int NP = `NUM_PORTS;
  localparam int IFG = `IFG_BYTES;
  localparam int EXP_MAX = 4096;
  // watchdog budget from the worst case bytes and frames over all tests
  localparam int FRAME_BYTES = 20 + 48 + 52 + (`FIFO_DEPTH + 10 + 20) + 20 * 40;
  localparam int NUM_FRAMES = 29;
  localparam int RESET_CYCLES = 20;
  localparam int LIMIT_CYCLES = (FRAME_BYTES + NUM_FRAMES * (IFG + 10)) * NP + RESET_CYCLES;

  logic                                    clk = 1'b0;
  logic                                    rst;
  eth_hub_pkg::phy_byte_t [`NUM_PORTS-1:0] rx_in;
  eth_hub_pkg::phy_byte_t [`NUM_PORTS-1:0] tx_out;
  logic [`NUM_PORTS-1:0][15:0]             trunc_count;

  int unsigned cyc = 0;
  int          errors = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          err_at_start;
  string       cur_test = "reset";

  logic [7:0] pay [NP][128]; // frame being built per source port
  int         pay_len [NP];
  int         last_in_cyc [NP];

  // expected traffic per output lane
  logic [7:0] exp_byte [NP][EXP_MAX];
  int         exp_len [NP][256];
  int         byte_wr [NP];
  int         byte_rd [NP];
  int         len_wr [NP];
  int         len_rd [NP];

  // output monitor state
  logic in_frm [NP];
  logic in_bad [NP];
  int   frm_cnt [NP];
  int   first_out_cyc [NP];
  int   gap_log [64];
  int   gap_n = 0;
  int   idle_run = 0;
  logic act_prev = 1'b0;
  logic seen_act = 1'b0;

  eth_hub_top i_eth_hub_top (
    .clk         (clk),
    .rst         (rst),
    .rx_in       (rx_in),
    .tx_out      (tx_out),
    .trunc_count (trunc_count)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  // outputs change on the rising edge, so sample them on the falling one
  always @(negedge clk) begin : monitor
    logic any_v;
    any_v = 1'b0;
    for (int p = 0; p < NP; p++) begin
      if (rst) begin
        in_frm[p] = 1'b0;
      end else if (tx_out[p].v) begin
        any_v = 1'b1;
        if (!in_frm[p]) begin
          in_frm[p]        = 1'b1;
          frm_cnt[p]       = 0;
          first_out_cyc[p] = cyc;
          in_bad[p]        = (len_rd[p] == len_wr[p]);
          if (in_bad[p]) begin
            $display("%s: port %0d received a frame it should not get", cur_test, p);
            errors++;
          end
        end
        if (!in_bad[p]) begin
          check($sformatf("%s port %0d byte %0d", cur_test, p, frm_cnt[p]),
                exp_byte[p][byte_rd[p]], tx_out[p].d);
          byte_rd[p]++;
        end
        frm_cnt[p]++;
      end else if (in_frm[p]) begin
        in_frm[p] = 1'b0;
        if (!in_bad[p]) begin
          check($sformatf("%s port %0d length", cur_test, p), exp_len[p][len_rd[p]], frm_cnt[p]);
          len_rd[p]++;
        end
      end
    end
    // idle cycles on all lanes between two frames
    if (any_v) begin
      if (!act_prev && seen_act && gap_n < 64) begin
        gap_log[gap_n] = idle_run;
        gap_n++;
      end
      seen_act = 1'b1;
      idle_run = 0;
    end else begin
      idle_run++;
    end
    act_prev = any_v;
  end

  task automatic apply_reset();
    rst   = 1'b1;
    rx_in = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic make_frame(input int p, input int len, input bit rnd);
    for (int i = 0; i < len; i++) begin
      pay[p][i] = rnd ? 8'($urandom) : 8'(p * 40 + i);
    end
    pay_len[p] = len;
  endtask

  // every lane except the source gets the first n bytes
  task automatic expect_frame(input int p, input int n);
    for (int q = 0; q < NP; q++) begin
      if (q != p) begin
        for (int i = 0; i < n; i++) begin
          exp_byte[q][byte_wr[q]] = pay[p][i];
          byte_wr[q]++;
        end
        exp_len[q][len_wr[q]] = n;
        len_wr[q]++;
      end
    end
  endtask

  task automatic drive_frame(input int p);
    for (int i = 0; i < pay_len[p]; i++) begin
      @(negedge clk);
      rx_in[p].v = 1'b1;
      rx_in[p].d = pay[p][i];
      last_in_cyc[p] = cyc;
    end
    @(negedge clk);
    rx_in[p].v = 1'b0;
    rx_in[p].d = 8'h00;
  endtask

  function automatic int frames_pending();
    int n;
    n = 0;
    for (int q = 0; q < NP; q++) begin
      n += (len_wr[q] - len_rd[q]) + (byte_wr[q] - byte_rd[q]);
    end
    return n;
  endfunction

  // no valid on any tx lane
  function automatic logic lanes_idle();
    logic idle;
    idle = 1'b1;
    for (int q = 0; q < NP; q++) begin
      if (tx_out[q].v) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  // all expected frames seen and the lines quiet for a while
  task automatic wait_drain();
    int quiet;
    quiet = 0;
    while (quiet < IFG + 5) begin
      @(negedge clk);
      if (frames_pending() == 0 && lanes_idle()) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = errors;
  endtask

  task automatic finish_test();
    if (errors == err_at_start) begin
      $display("test %s passed", cur_test);
      n_pass++;
    end else begin
      $display("test %s failed with %0d errors", cur_test, errors - err_at_start);
      n_fail++;
    end
  endtask

  task automatic single_frame_test();
    start_test("single_frame");
    make_frame(0, 20, 1'b0);
    expect_frame(0, 20);
    drive_frame(0);
    wait_drain();
    // last write, frame count, then three cycles of forwarder start
    check("single_frame latency port 1", 5, first_out_cyc[1] - last_in_cyc[0]);
    check("single_frame latency port 2", 5, first_out_cyc[2] - last_in_cyc[0]);
    finish_test();
  endtask

  // shortest frame first, so every port has finished before its turn
  task automatic three_port_burst(input int l0, input int l1, input int l2);
    make_frame(0, l0, 1'b1);
    make_frame(1, l1, 1'b1);
    make_frame(2, l2, 1'b1);
    expect_frame(0, l0);
    expect_frame(1, l1);
    expect_frame(2, l2);
    fork
      drive_frame(0);
      drive_frame(1);
      drive_frame(2);
    join
    wait_drain();
  endtask

  task automatic round_robin_test();
    apply_reset();
    start_test("round_robin");
    three_port_burst(8, 16, 24);
    finish_test();
  endtask

  task automatic gap_test();
    start_test("inter_frame_gap");
    gap_n = 0;
    three_port_burst(10, 12, 30);
    check("inter_frame_gap count", 3, gap_n);
    check("inter_frame_gap first", IFG, gap_log[1]);
    check("inter_frame_gap second", IFG, gap_log[2]);
    finish_test();
  endtask

  task automatic overflow_test();
    start_test("overflow");
    make_frame(0, `FIFO_DEPTH + 10, 1'b0);
    expect_frame(0, `FIFO_DEPTH); // tail is lost
    drive_frame(0);
    make_frame(0, 20, 1'b1);
    expect_frame(0, 20);
    drive_frame(0);
    wait_drain();
    check("overflow trunc_count 0", 1, trunc_count[0]);
    check("overflow trunc_count 1", 0, trunc_count[1]);
    check("overflow trunc_count 2", 0, trunc_count[2]);
    finish_test();
  endtask

  task automatic random_frames_test();
    int p;
    int len;
    start_test("random_frames");
    for (int i = 0; i < 20; i++) begin
      p   = $urandom % NP;
      len = 1 + $urandom % 40;
      make_frame(p, len, 1'b1);
      expect_frame(p, len);
      drive_frame(p);
      wait_drain();
    end
    // only the overflow frame was cut since the last reset
    for (int q = 0; q < NP; q++) begin
      check($sformatf("random_frames trunc_count %0d", q), (q == 0) ? 1 : 0, trunc_count[q]);
    end
    finish_test();
  endtask

  initial begin : watchdog
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: the hub did not deliver all expected frames in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main
    int seed_out;
    rst      = 1'b1;
    rx_in    = '0;
    seed_out = $urandom(32'h2dce);
    for (int q = 0; q < NP; q++) begin
      byte_wr[q] = 0;
      byte_rd[q] = 0;
      len_wr[q]  = 0;
      len_rd[q]  = 0;
      in_frm[q]  = 1'b0;
      in_bad[q]  = 1'b0;
    end
    apply_reset();
    single_frame_test();
    round_robin_test();
    gap_test();
    overflow_test();
    random_frames_test();
    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tb_eth_hub

/* src.f */
+incdir+.
eth_hub_pkg.sv
hub_port_rx.sv
frame_fifo.sv
rr_arbiter.sv
hub_forwarder.sv
eth_hub_top.sv
tb_eth_hub.sv
